// File: bus_controller.sv
`timescale 1ns/1ps

module bus_controller import bus_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [NUM_DEVICES-1:0] req,
  input  bus_data_t              dev_data [NUM_DEVICES],
  input  bus_ctrl_t              dev_ctrl [NUM_DEVICES],
  output logic [NUM_DEVICES-1:0] ack,
  output bus_data_t              bus_data,
  output bus_ctrl_t              bus_ctrl
);
  localparam bus_ctrl_t IDLE_CTRL = '{op: bus_idle, dest: '0, src: '0};

  logic [NUM_DEVICES-1:0] eligible;
  dev_id_t                ptr;
  dev_id_t                idx;
  dev_id_t                winner;
  logic                   grant;

  assign eligible = req & ~ack; // a held req is not granted twice

  // first eligible requester at or after the pointer
  always_comb begin
    grant  = 1'b0;
    winner = ptr;
    idx    = ptr;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      idx = dev_id_t'(ptr + dev_id_t'(i));
      if (!grant && eligible[idx]) begin
        grant  = 1'b1;
        winner = idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ack      <= '0;
      ptr      <= '0;
      bus_ctrl <= IDLE_CTRL;
    end else begin
      ack      <= '0;
      bus_ctrl <= IDLE_CTRL; // idle unless granted
      if (grant) begin
        ack[winner] <= 1'b1;
        ptr         <= winner + 3'd1; // search resumes past the winner
        bus_ctrl    <= dev_ctrl[winner];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      bus_data <= dev_data[winner];
    end
  end

  granted_op_valid: assert property (
    @(posedge clk) disable iff (reset)
    (ack != '0) |-> (bus_ctrl.op != bus_idle) // requester had a real operation
  );

  req_drop_after_ack: assert property (
    @(posedge clk) disable iff (reset)
    (req & $past(ack)) == '0
  );

endmodule

// File: bus_memory.sv
`timescale 1ns/1ps

module bus_memory import bus_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic      clk,
  input  logic      reset,
  input  bus_data_t bus_data,
  input  bus_ctrl_t bus_ctrl,
  input  logic      ack,
  output logic      req,
  output bus_data_t data_out,
  output bus_ctrl_t ctrl_out
);
  localparam int AW = $clog2(MEM_WORDS);

  mem_word_t     mem [MEM_WORDS];
  addr_t         req_addr;
  logic [AW-1:0] word_idx;
  logic          hit;
  logic          wr_hit;
  logic          rd_hit;

  assign req_addr = bus_data[31:16];
  assign word_idx = AW'(req_addr % MEM_WORDS); // addresses alias past the depth
  assign hit      = (bus_ctrl.op != bus_idle) && (bus_ctrl.dest == MEM_BUS_ID);
  assign wr_hit   = hit && (bus_ctrl.op == bus_write);
  assign rd_hit   = hit && (bus_ctrl.op == bus_read);

  always_ff @(posedge clk) begin
    if (reset) begin
      req <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (ack) begin
        req <= 1'b0; // reply went out this cycle
      end else if (rd_hit) begin
        req <= 1'b1;
      end
      if (wr_hit) begin
        mem[word_idx] <= bus_data[15:0];
      end
    end
  end

  // single reply slot
  always_ff @(posedge clk) begin
    if (rd_hit) begin
      data_out <= {req_addr, mem[word_idx]};
      ctrl_out <= '{op: bus_reply, dest: bus_ctrl.src, src: MEM_BUS_ID};
    end
  end

  no_read_while_pending: assert property (
    @(posedge clk) disable iff (reset)
    rd_hit |-> !req
  );

endmodule

// File: bus_pkg.sv
package bus_pkg;

  localparam int NUM_DEVICES = 8; // req and ack width

  typedef logic [31:0] bus_data_t;
  typedef logic [15:0] addr_t;
  typedef logic [15:0] mem_word_t;
  typedef logic [2:0]  dev_id_t;

  typedef enum logic [1:0] {
    bus_idle  = 2'd0,
    bus_write = 2'd1,
    bus_read  = 2'd2,
    bus_reply = 2'd3
  } bus_op_e;

  // control word broadcast next to the data word
  typedef struct packed {
    bus_op_e op;
    dev_id_t dest;
    dev_id_t src;
  } bus_ctrl_t;

  localparam dev_id_t MEM_BUS_ID  = 3'd0;
  localparam dev_id_t UART_BUS_ID = 3'd6;

  localparam logic [7:0] FRAME_WRITE = 8'h57; // 'W'
  localparam logic [7:0] FRAME_READ  = 8'h52; // 'R'

  typedef enum logic [3:0] {
    br_idle,
    br_addr_hi,
    br_addr_lo,
    br_data_hi,
    br_data_lo,
    br_request,
    br_wait_reply,
    br_send_hi,
    br_send_lo
  } bridge_state_e;

endpackage

// File: system.sv
`timescale 1ns/1ps

module system import bus_pkg::*; #(
  parameter int CLKS_PER_BIT = 434, // 25 MHz at 57600 baud
  parameter int MEM_WORDS    = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic rx,
  output logic tx
);
  logic [NUM_DEVICES-1:0] req;
  logic [NUM_DEVICES-1:0] ack;
  bus_data_t              dev_data [NUM_DEVICES];
  bus_ctrl_t              dev_ctrl [NUM_DEVICES];
  bus_data_t              bus_data;
  bus_ctrl_t              bus_ctrl;

  // empty slots stay quiet
  for (genvar i = 0; i < NUM_DEVICES; i++) begin : g_slot
    if (i != MEM_BUS_ID && i != UART_BUS_ID) begin : g_unused
      assign req[i]      = 1'b0;
      assign dev_data[i] = '0;
      assign dev_ctrl[i] = '0;
    end
  end

  bus_controller bus_controller_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .dev_data(dev_data),
    .dev_ctrl(dev_ctrl),
    .ack     (ack),
    .bus_data(bus_data),
    .bus_ctrl(bus_ctrl)
  );

  bus_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) bus_memory_i (
    .clk     (clk),
    .reset   (reset),
    .bus_data(bus_data),
    .bus_ctrl(bus_ctrl),
    .ack     (ack[MEM_BUS_ID]),
    .req     (req[MEM_BUS_ID]),
    .data_out(dev_data[MEM_BUS_ID]),
    .ctrl_out(dev_ctrl[MEM_BUS_ID])
  );

  uart_bridge #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) uart_bridge_i (
    .clk     (clk),
    .reset   (reset),
    .rx      (rx),
    .tx      (tx),
    .bus_data(bus_data),
    .bus_ctrl(bus_ctrl),
    .ack     (ack[UART_BUS_ID]),
    .req     (req[UART_BUS_ID]),
    .data_out(dev_data[UART_BUS_ID]),
    .ctrl_out(dev_ctrl[UART_BUS_ID])
  );

endmodule

// File: system_tb.sv
`timescale 1ns/1ps

module system_tb import bus_pkg::*; ;
  localparam int CLKS_PER_BIT = 16;
  localparam int MEM_WORDS    = 256;
  localparam int DRIVE_DELAY  = 2;
  localparam int NUM_PAIRS    = 40;
  localparam int NUM_ALIAS    = 4;
  localparam int NUM_MIXED    = 60;
  localparam int NUM_FRAMES   = 1 + 2 * NUM_PAIRS + 3 + 3 * NUM_ALIAS + 2 + NUM_MIXED + 1;
  // frames x 10 bytes x 10 bits x clocks per bit x 20 ns, doubled
  localparam longint TIMEOUT_NS = longint'(NUM_FRAMES) * 10 * 10 * CLKS_PER_BIT * 20 * 2;

  typedef struct packed {
    addr_t     addr;
    mem_word_t data;
  } reply_t;

  logic       clk;
  logic       reset;
  logic       rx = 1'b1;
  logic       tx;
  logic       tx_active = 1'b0;
  mem_word_t  ref_mem [MEM_WORDS];
  logic [7:0] tx_bytes [$];
  reply_t     expected [$];
  int         reads_sent = 0;
  int         replies_checked = 0;
  int         bytes_seen = 0;

  tb_clock_gen #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(4)
  ) clock_gen_i (
    .clk  (clk),
    .reset(reset)
  );

  system #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .MEM_WORDS   (MEM_WORDS)
  ) system_i (
    .clk  (clk),
    .reset(reset),
    .rx   (rx),
    .tx   (tx)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // memory model, address wraps at the depth
  function automatic mem_word_t ref_access(input logic is_write, input addr_t addr,
                                           input mem_word_t data);
    int idx;
    idx = int'(addr) % MEM_WORDS;
    if (is_write) ref_mem[idx] = data;
    return ref_mem[idx];
  endfunction

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // stop, data, start
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  task automatic write_frame(input addr_t addr, input mem_word_t data);
    void'(ref_access(1'b1, addr, data));
    send_byte(FRAME_WRITE);
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
    send_byte(data[15:8]);
    send_byte(data[7:0]);
  endtask

  task automatic read_frame(input addr_t addr);
    expected.push_back('{addr: addr, data: ref_access(1'b0, addr, '0)});
    send_byte(FRAME_READ);
    send_byte(addr[15:8]);
    send_byte(addr[7:0]);
    reads_sent++;
    wait (replies_checked == reads_sent); // host waits for the reply
  endtask

  initial begin : tx_monitor
    logic [7:0] b;
    wait (reset === 1'b0);
    forever begin
      @(negedge tx);
      tx_active = 1'b1;
      repeat (CLKS_PER_BIT / 2) @(negedge clk); // middle of the start bit
      assert (tx == 1'b0) else fail_run("start bit on tx did not stay low");
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        b[i] = tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      assert (tx == 1'b1) else fail_run("stop bit on tx was low");
      tx_bytes.push_back(b);
      bytes_seen++;
      tx_active = 1'b0;
    end
  end

  initial begin : compare_replies
    logic [7:0] hi;
    logic [7:0] lo;
    reply_t     exp;
    forever begin
      wait (tx_bytes.size() >= 2);
      hi = tx_bytes.pop_front(); // high byte first
      lo = tx_bytes.pop_front();
      assert (expected.size() > 0)
        else fail_run("reply bytes arrived on tx with no read outstanding");
      exp = expected.pop_front();
      assert ({hi, lo} == exp.data)
        else fail_run($sformatf("FAIL %0t ns: read of 0x%04h returned 0x%04h, expected 0x%04h",
                                $time, exp.addr, {hi, lo}, exp.data));
      replies_checked++;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    fail_run("timeout: the replies on tx did not arrive in the allowed time");
  end

  initial begin : stimulus
    addr_t      a;
    mem_word_t  d;
    logic [7:0] stray;
    void'($urandom(32'hbb6793bc));
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = '0;
    wait (reset === 1'b0);
    @(posedge clk);

    read_frame(16'h0005); // never written, reads zero

    for (int i = 0; i < NUM_PAIRS; i++) begin
      a = addr_t'($urandom);
      d = mem_word_t'($urandom);
      write_frame(a, d);
      read_frame(a);
    end

    a = addr_t'($urandom);
    d = mem_word_t'($urandom);
    write_frame(a, d);
    write_frame(a, ~d); // last write wins
    read_frame(a);

    // same low byte, different upper byte
    for (int i = 0; i < NUM_ALIAS; i++) begin
      a = {8'($urandom_range(1, 255)), 8'($urandom)};
      d = mem_word_t'($urandom);
      write_frame(a, d);
      read_frame({8'($urandom_range(1, 255)), a[7:0]});
      read_frame({8'h00, a[7:0]});
    end

    stray = 8'($urandom);
    if (stray == FRAME_WRITE || stray == FRAME_READ) stray = 8'h3f;
    send_byte(stray);
    read_frame(a);

    for (int i = 0; i < NUM_MIXED; i++) begin
      a = addr_t'($urandom) & 16'hf01f; // small set of words, upper bits alias
      if ($urandom_range(0, 1) == 1) begin
        write_frame(a, mem_word_t'($urandom));
      end else begin
        read_frame(a);
      end
    end

    repeat (5 * 10 * CLKS_PER_BIT) @(posedge clk); // quiet for one frame
    assert (tx_bytes.size() == 0 && expected.size() == 0 && !tx_active &&
            bytes_seen == 2 * reads_sent)
      else fail_run("tx sent extra or missing bytes after the last frame");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0; // released just after the edge
  end

endmodule

// File: uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge import bus_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      rx,
  output logic      tx,
  input  bus_data_t bus_data,
  input  bus_ctrl_t bus_ctrl,
  input  logic      ack,
  output logic      req,
  output bus_data_t data_out,
  output bus_ctrl_t ctrl_out
);
  bridge_state_e state;
  logic [7:0]    rx_byte;
  logic          rx_valid;
  logic [7:0]    tx_byte;
  logic          tx_start;
  logic          tx_busy;
  logic          tx_go;
  logic          is_read;
  addr_t         addr;
  mem_word_t     wdata;
  mem_word_t     rdata;
  logic          reply_hit;

  uart_receiver #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) receiver_i (
    .clk       (clk),
    .reset     (reset),
    .rx        (rx),
    .byte_out  (rx_byte),
    .byte_valid(rx_valid)
  );

  uart_transmitter #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) transmitter_i (
    .clk    (clk),
    .reset  (reset),
    .start  (tx_start),
    .byte_in(tx_byte),
    .tx     (tx),
    .busy   (tx_busy)
  );

  assign reply_hit = (bus_ctrl.op == bus_reply) && (bus_ctrl.dest == UART_BUS_ID);
  // busy lags start by a cycle
  assign tx_go     = (state == br_send_hi || state == br_send_lo) && !tx_busy && !tx_start;
  assign data_out  = {addr, wdata};
  assign ctrl_out  = '{op: is_read ? bus_read : bus_write, dest: MEM_BUS_ID, src: UART_BUS_ID};

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= br_idle;
      req      <= 1'b0;
      tx_start <= 1'b0;
      is_read  <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        br_idle: begin
          if (rx_valid && rx_byte == FRAME_WRITE) begin
            is_read <= 1'b0;
            state   <= br_addr_hi;
          end else if (rx_valid && rx_byte == FRAME_READ) begin
            is_read <= 1'b1;
            state   <= br_addr_hi;
          end
        end
        br_addr_hi: if (rx_valid) state <= br_addr_lo;
        br_addr_lo: begin
          if (rx_valid && is_read) begin
            req   <= 1'b1;
            state <= br_request;
          end else if (rx_valid) begin
            state <= br_data_hi;
          end
        end
        br_data_hi: if (rx_valid) state <= br_data_lo;
        br_data_lo: begin
          if (rx_valid) begin
            req   <= 1'b1;
            state <= br_request;
          end
        end
        br_request: begin
          if (ack) begin
            req   <= 1'b0;
            state <= is_read ? br_wait_reply : br_idle;
          end
        end
        br_wait_reply: if (reply_hit) state <= br_send_hi;
        br_send_hi: begin
          if (tx_go) begin
            tx_start <= 1'b1;
            state    <= br_send_lo;
          end
        end
        br_send_lo: begin
          if (tx_go) begin
            tx_start <= 1'b1;
            state    <= br_idle;
          end
        end
        default: state <= br_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && state == br_addr_hi) addr[15:8] <= rx_byte;
    if (rx_valid && state == br_addr_lo) addr[7:0] <= rx_byte;
    if (rx_valid && state == br_data_hi) wdata[15:8] <= rx_byte;
    if (rx_valid && state == br_data_lo) wdata[7:0] <= rx_byte;
    if (state == br_wait_reply && reply_hit) rdata <= bus_data[15:0];
    if (tx_go) tx_byte <= (state == br_send_hi) ? rdata[15:8] : rdata[7:0]; // high byte first
  end

endmodule

// File: uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       rx,
  output logic [7:0] byte_out,
  output logic       byte_valid
);
  localparam int CW = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e     state;
  logic [1:0]    rx_sync;
  logic          rx_s;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  logic [7:0]    shift_reg;
  logic          bit_end;
  logic          mid_start;

  assign rx_s      = rx_sync[1];
  assign bit_end   = clk_cnt == CW'(CLKS_PER_BIT - 1);
  assign mid_start = clk_cnt == CW'(CLKS_PER_BIT / 2 - 1);
  assign byte_out  = shift_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_sync    <= 2'b11; // line idles high
      state      <= rx_idle;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      rx_sync    <= {rx_sync[0], rx};
      byte_valid <= 1'b0;
      clk_cnt    <= clk_cnt + 1'b1;
      case (state)
        rx_idle: begin
          clk_cnt <= '0;
          if (!rx_s) state <= rx_start;
        end
        rx_start: begin
          if (mid_start) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s ? rx_idle : rx_data; // glitch, not a start bit
          end
        end
        rx_data: begin
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= rx_stop;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            byte_valid <= rx_s; // framing error drops the byte
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_data && bit_end) begin
      shift_reg <= {rx_s, shift_reg[7:1]}; // lsb first
    end
  end

endmodule

// File: uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic [7:0] byte_in,
  output logic       tx,
  output logic       busy
);
  localparam int CW = $clog2(CLKS_PER_BIT);

  logic [CW-1:0] clk_cnt;
  logic [3:0]    bit_cnt;
  logic [8:0]    shift_reg;
  logic          bit_end;

  assign bit_end = clk_cnt == CW'(CLKS_PER_BIT - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx      <= 1'b1;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      clk_cnt <= '0;
      bit_cnt <= '0;
      if (start) begin
        tx   <= 1'b0; // start bit
        busy <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 4'd1;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0; // stop bit done, tx stays high
      end else begin
        tx <= shift_reg[0];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shift_reg <= {1'b1, byte_in}; // stop bit above the data
    end else if (busy && bit_end) begin
      shift_reg <= {1'b1, shift_reg[8:1]};
    end
  end

  start_while_busy: assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !start
  );

endmodule

// File: vlog.f
bus_pkg.sv
bus_controller.sv
bus_memory.sv
uart_receiver.sv
uart_transmitter.sv
uart_bridge.sv
system.sv
tb_clock_gen.sv
system_tb.sv
